/* common/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// number of crate links
`define BRIDGE_NUM_LANES 4

// crate address is {lane, local address}
`define BRIDGE_CRATE_ADDR_W 27
`define BRIDGE_LANE_ADDR_W 25

// register data width
`define BRIDGE_DATA_W 32

// per-lane command FIFO, also the starting credit count
`define BRIDGE_FIFO_DEPTH 2

// cycles a read waits for its link reply
`define BRIDGE_TIMEOUT 64

// read data returned on any error
`define BRIDGE_ERR_DATA 32'hDEADDEAD

`endif

/* common/bridge_pkg.sv */
`include "bridge_defs.svh"

package bridge_pkg;

    ////////////////////////////////////////
    // plain vectors
    ////////////////////////////////////////

    typedef logic [`BRIDGE_CRATE_ADDR_W-1:0] crate_addr_t;
    typedef logic [`BRIDGE_LANE_ADDR_W-1:0] lane_addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0] reg_data_t;
    typedef logic [$clog2(`BRIDGE_NUM_LANES)-1:0] lane_id_t;
    typedef logic [`BRIDGE_NUM_LANES-1:0] lane_mask_t;
    // counts 0 up to the FIFO depth
    typedef logic [$clog2(`BRIDGE_FIFO_DEPTH+1)-1:0] credit_t;

    ////////////////////////////////////////
    // bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic        we;
        crate_addr_t addr;
        reg_data_t   wdata;
    } host_req_t;

    typedef struct packed {
        logic      valid;
        logic      err;
        reg_data_t rdata;
    } host_rsp_t;

    // dispatcher to channel, and channel to link
    typedef struct packed {
        logic       valid;
        logic       we;
        lane_addr_t addr;
        reg_data_t  data;
    } lane_cmd_t;

    // link to channel, and channel to collector
    typedef struct packed {
        logic      valid;
        reg_data_t data;
    } lane_rsp_t;

    // completion made inside the dispatcher
    typedef struct packed {
        logic valid;
        logic err;
    } local_cpl_t;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_SEND,
        CH_WAIT_RSP
    } chan_state_e;

endpackage

/* crate_bridge.f */
+incdir+common
common/bridge_pkg.sv
hw/bridge_cmd_dispatch.sv
link/link_channel.sv
hw/bridge_resp_collect.sv
hw/crate_bridge_top.sv
testbench/tb_clock_gen.sv
testbench/tb_crate_bridge.sv

/* hw/bridge_cmd_dispatch.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module bridge_cmd_dispatch (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    input  bridge_pkg::host_req_t  host_req_i,
    input  bridge_pkg::lane_mask_t link_up_i,
    input  bridge_pkg::lane_mask_t credit_ret_i,
    input  logic                   rsp_done_i,
    output bridge_pkg::lane_cmd_t  lane_cmd_o [`BRIDGE_NUM_LANES],
    output bridge_pkg::local_cpl_t local_cpl_o,
    output bridge_pkg::lane_mask_t invalid_o
);

    bridge_pkg::lane_id_t   req_lane;
    bridge_pkg::lane_addr_t req_addr;
    logic                   lane_up;
    logic                   accept;
    bridge_pkg::lane_mask_t push_nxt;

    bridge_pkg::credit_t    credit_q [`BRIDGE_NUM_LANES];
    logic                   busy_q;
    bridge_pkg::lane_mask_t push_q;
    bridge_pkg::lane_mask_t invalid_q;
    logic                   cpl_valid_q;
    logic                   cpl_err_q;
    logic                   cmd_we_q;
    bridge_pkg::lane_addr_t cmd_addr_q;
    bridge_pkg::reg_data_t  cmd_data_q;

    // top bits pick the lane
    assign {req_lane, req_addr} = host_req_i.addr;
    assign lane_up = link_up_i[req_lane];

    // down lanes complete at once, up lanes need a credit
    assign accept = host_req_i.valid && !busy_q &&
                    (!lane_up || (credit_q[req_lane] != '0));

    always_comb begin
        for (int n = 0; n < `BRIDGE_NUM_LANES; n++) begin
            push_nxt[n] = accept && lane_up && (req_lane == bridge_pkg::lane_id_t'(n));
        end
    end

    ////////////////////////////////////////
    // credit counters
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        for (int n = 0; n < `BRIDGE_NUM_LANES; n++) begin
            if (rst_i) begin
                credit_q[n] <= bridge_pkg::credit_t'(`BRIDGE_FIFO_DEPTH);
            end else if (credit_ret_i[n] && !push_nxt[n]) begin
                credit_q[n] <= credit_q[n] + bridge_pkg::credit_t'(1);
            end else if (push_nxt[n] && !credit_ret_i[n]) begin
                credit_q[n] <= credit_q[n] - bridge_pkg::credit_t'(1);
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            busy_q      <= 1'b0;
            push_q      <= '0;
            invalid_q   <= '0;
            cpl_valid_q <= 1'b0;
        end else begin
            push_q      <= push_nxt;
            // writes are posted, down lanes fail locally
            cpl_valid_q <= accept && (!lane_up || host_req_i.we);
            if (accept) begin
                busy_q <= 1'b1;
            end else if (rsp_done_i) begin
                busy_q <= 1'b0;
            end
            if (accept && !lane_up) begin
                invalid_q[req_lane] <= 1'b1;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (accept) begin
            cmd_we_q   <= host_req_i.we;
            cmd_addr_q <= req_addr;
            cmd_data_q <= host_req_i.wdata;
            cpl_err_q  <= !lane_up;
        end
    end

    always_comb begin
        for (int n = 0; n < `BRIDGE_NUM_LANES; n++) begin
            lane_cmd_o[n].valid = push_q[n];
            lane_cmd_o[n].we    = cmd_we_q;
            lane_cmd_o[n].addr  = cmd_addr_q;
            lane_cmd_o[n].data  = cmd_data_q;
        end
        local_cpl_o.valid = cpl_valid_q;
        local_cpl_o.err   = cpl_err_q;
    end

    assign invalid_o = invalid_q;

endmodule

/* hw/bridge_resp_collect.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module bridge_resp_collect (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    input  bridge_pkg::local_cpl_t local_cpl_i,
    input  bridge_pkg::lane_rsp_t  lane_rsp_i [`BRIDGE_NUM_LANES],
    input  bridge_pkg::lane_mask_t lane_timeout_i,
    output bridge_pkg::host_rsp_t  host_rsp_o,
    output bridge_pkg::lane_mask_t timeout_o
);

    bridge_pkg::host_rsp_t  rsp_nxt;
    logic                   rsp_valid_q;
    logic                   rsp_err_q;
    bridge_pkg::reg_data_t  rsp_data_q;
    bridge_pkg::lane_mask_t timeout_q;

    // one request in flight, so at most one source fires
    always_comb begin
        rsp_nxt = '0;
        if (local_cpl_i.valid) begin
            rsp_nxt.valid = 1'b1;
            rsp_nxt.err   = local_cpl_i.err;
            rsp_nxt.rdata = local_cpl_i.err ? `BRIDGE_ERR_DATA : '0;
        end
        for (int n = 0; n < `BRIDGE_NUM_LANES; n++) begin
            if (lane_rsp_i[n].valid) begin
                rsp_nxt.valid = 1'b1;
                rsp_nxt.err   = 1'b0;
                rsp_nxt.rdata = lane_rsp_i[n].data;
            end
            if (lane_timeout_i[n]) begin
                rsp_nxt.valid = 1'b1;
                rsp_nxt.err   = 1'b1;
                rsp_nxt.rdata = `BRIDGE_ERR_DATA;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            timeout_q   <= '0;
        end else begin
            rsp_valid_q <= rsp_nxt.valid;
            // sticky per lane
            timeout_q   <= timeout_q | lane_timeout_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        rsp_err_q  <= rsp_nxt.err;
        rsp_data_q <= rsp_nxt.rdata;
    end

    always_comb begin
        host_rsp_o.valid = rsp_valid_q;
        host_rsp_o.err   = rsp_err_q;
        host_rsp_o.rdata = rsp_data_q;
    end

    assign timeout_o = timeout_q;

endmodule

/* hw/crate_bridge_top.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module crate_bridge_top (
    input  logic                   ps_clk,
    input  logic                   rst_i,
    input  bridge_pkg::host_req_t  host_req_i,
    input  bridge_pkg::lane_mask_t link_up_i,
    input  bridge_pkg::lane_mask_t link_cmd_ready_i,
    input  bridge_pkg::lane_rsp_t  link_rsp_i [`BRIDGE_NUM_LANES],
    output bridge_pkg::host_rsp_t  host_rsp_o,
    output bridge_pkg::lane_cmd_t  link_cmd_o [`BRIDGE_NUM_LANES],
    output bridge_pkg::lane_mask_t timeout_o,
    output bridge_pkg::lane_mask_t invalid_o
);

    bridge_pkg::lane_cmd_t  lane_cmd [`BRIDGE_NUM_LANES];
    bridge_pkg::lane_rsp_t  lane_rsp [`BRIDGE_NUM_LANES];
    bridge_pkg::lane_mask_t credit_ret;
    bridge_pkg::lane_mask_t lane_timeout;
    bridge_pkg::local_cpl_t local_cpl;

    ////////////////////////////////////////
    // request side
    ////////////////////////////////////////

    // response pulse frees the dispatcher for the next request
    bridge_cmd_dispatch u_dispatch (
        .ps_clk       (ps_clk),
        .rst_i        (rst_i),
        .host_req_i   (host_req_i),
        .link_up_i    (link_up_i),
        .credit_ret_i (credit_ret),
        .rsp_done_i   (host_rsp_o.valid),
        .lane_cmd_o   (lane_cmd),
        .local_cpl_o  (local_cpl),
        .invalid_o    (invalid_o)
    );

    // one channel per crate link
    for (genvar n = 0; n < `BRIDGE_NUM_LANES; n++) begin : g_lane
        link_channel u_chan (
            .ps_clk           (ps_clk),
            .rst_i            (rst_i),
            .cmd_i            (lane_cmd[n]),
            .link_cmd_ready_i (link_cmd_ready_i[n]),
            .link_rsp_i       (link_rsp_i[n]),
            .credit_ret_o     (credit_ret[n]),
            .link_cmd_o       (link_cmd_o[n]),
            .rsp_o            (lane_rsp[n]),
            .timeout_o        (lane_timeout[n])
        );
    end

    ////////////////////////////////////////
    // response side
    ////////////////////////////////////////

    bridge_resp_collect u_collect (
        .ps_clk         (ps_clk),
        .rst_i          (rst_i),
        .local_cpl_i    (local_cpl),
        .lane_rsp_i     (lane_rsp),
        .lane_timeout_i (lane_timeout),
        .host_rsp_o     (host_rsp_o),
        .timeout_o      (timeout_o)
    );

endmodule

/* link/link_channel.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module link_channel (
    input  logic                  ps_clk,
    input  logic                  rst_i,
    input  bridge_pkg::lane_cmd_t cmd_i,
    input  logic                  link_cmd_ready_i,
    input  bridge_pkg::lane_rsp_t link_rsp_i,
    output logic                  credit_ret_o,
    output bridge_pkg::lane_cmd_t link_cmd_o,
    output bridge_pkg::lane_rsp_t rsp_o,
    output logic                  timeout_o
);

    localparam int PTR_W = $clog2(`BRIDGE_FIFO_DEPTH);
    localparam int TMR_W = $clog2(`BRIDGE_TIMEOUT);

    bridge_pkg::lane_cmd_t   fifo_mem [`BRIDGE_FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    bridge_pkg::credit_t     fill_q;
    logic                    pop;

    bridge_pkg::chan_state_e state_q;
    logic [TMR_W-1:0]        timer_q;
    logic                    tx_valid_q;
    bridge_pkg::lane_cmd_t   tx_q;
    logic                    rsp_valid_q;
    bridge_pkg::reg_data_t   rsp_data_q;
    logic                    credit_q;
    logic                    timeout_q;

    // head leaves the FIFO only when the link side is free
    assign pop = (state_q == bridge_pkg::CH_IDLE) && (fill_q != '0);

    ////////////////////////////////////////
    // command FIFO
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (cmd_i.valid) begin
            fifo_mem[wr_ptr_q] <= cmd_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (cmd_i.valid) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            if (cmd_i.valid && !pop) begin
                fill_q <= fill_q + bridge_pkg::credit_t'(1);
            end else if (pop && !cmd_i.valid) begin
                fill_q <= fill_q - bridge_pkg::credit_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // link FSM
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state_q     <= bridge_pkg::CH_IDLE;
            timer_q     <= '0;
            tx_valid_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
            credit_q    <= 1'b0;
            timeout_q   <= 1'b0;
        end else begin
            credit_q    <= pop;
            rsp_valid_q <= 1'b0;
            timeout_q   <= 1'b0;
            case (state_q)
                bridge_pkg::CH_IDLE: begin
                    if (pop) begin
                        tx_valid_q <= 1'b1;
                        state_q    <= bridge_pkg::CH_SEND;
                    end
                end
                bridge_pkg::CH_SEND: begin
                    if (link_cmd_ready_i) begin
                        tx_valid_q <= 1'b0;
                        timer_q    <= '0;
                        if (tx_q.we) begin
                            state_q <= bridge_pkg::CH_IDLE;
                        end else begin
                            state_q <= bridge_pkg::CH_WAIT_RSP;
                        end
                    end
                end
                bridge_pkg::CH_WAIT_RSP: begin
                    // a reply on the last cycle still wins
                    if (link_rsp_i.valid) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= bridge_pkg::CH_IDLE;
                    end else if (timer_q == TMR_W'(`BRIDGE_TIMEOUT - 1)) begin
                        timeout_q <= 1'b1;
                        state_q   <= bridge_pkg::CH_IDLE;
                    end else begin
                        timer_q <= timer_q + TMR_W'(1);
                    end
                end
                default: state_q <= bridge_pkg::CH_IDLE;
            endcase
        end
    end

    always_ff @(posedge ps_clk) begin
        if (pop) begin
            tx_q <= fifo_mem[rd_ptr_q];
        end
        if ((state_q == bridge_pkg::CH_WAIT_RSP) && link_rsp_i.valid) begin
            rsp_data_q <= link_rsp_i.data;
        end
    end

    always_comb begin
        link_cmd_o       = tx_q;
        link_cmd_o.valid = tx_valid_q;
        rsp_o.valid      = rsp_valid_q;
        rsp_o.data       = rsp_data_q;
    end

    assign credit_ret_o = credit_q;
    assign timeout_o    = timeout_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the crate bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f crate_bridge.f --top-module tb_crate_bridge \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1

grep -q "All checks passed" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

endmodule

/* testbench/tb_crate_bridge.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module tb_crate_bridge;

    localparam int N_WR = 6;
    localparam int N_BURST = 8;
    localparam int NUM_REQ = 2 * N_WR + 2 + 1 + N_BURST + 4;
    localparam int LIMIT = 16 + 200 * NUM_REQ;
    localparam int WATCH = 1;

    logic                   ps_clk;
    logic                   rst_i;
    bridge_pkg::host_req_t  host_req;
    bridge_pkg::lane_mask_t link_up;
    bridge_pkg::lane_mask_t link_ready = '1;
    bridge_pkg::lane_rsp_t  link_rsp [`BRIDGE_NUM_LANES] = '{default: '0};
    bridge_pkg::host_rsp_t  host_rsp;
    bridge_pkg::lane_cmd_t  link_cmd [`BRIDGE_NUM_LANES];
    bridge_pkg::lane_mask_t timeout_o;
    bridge_pkg::lane_mask_t invalid_o;

    integer      seed = 32'hfa10;
    int          checks = 0;
    int          errors = 0;
    int          cyc = 0;
    logic        ready_rand = 1'b0;
    logic        log_en = 1'b0;
    logic [3:0]  stalled = '0;
    logic [31:0] ref_mem [4][16];
    logic [31:0] link_mem [4][16];
    int          seen_valid [4];
    logic        pend [4];
    int          delay [4];
    logic [3:0]  pend_addr [4];
    logic [56:0] exp_q [$];
    logic [56:0] got_q [$];

    tb_clock_gen u_clk (.clk_o(ps_clk));

    crate_bridge_top dut0 (
        .ps_clk           (ps_clk),
        .rst_i            (rst_i),
        .host_req_i       (host_req),
        .link_up_i        (link_up),
        .link_cmd_ready_i (link_ready),
        .link_rsp_i       (link_rsp),
        .host_rsp_o       (host_rsp),
        .link_cmd_o       (link_cmd),
        .timeout_o        (timeout_o),
        .invalid_o        (invalid_o)
    );

    ////////////////////////////////////////
    // link models
    ////////////////////////////////////////

    always @(posedge ps_clk) begin
        for (int n = 0; n < 4; n++) begin
            link_rsp[n] <= '0;
            link_ready[n] <= ready_rand ? 1'($random(seed)) : 1'b1;
            if (rst_i) begin
                pend[n] = 1'b0;
                seen_valid[n] = 0;
                for (int a = 0; a < 16; a++) begin
                    link_mem[n][a] <= {16'hc0de, 10'd0, 2'(n), 4'(a)};
                end
            end else begin
                if (link_cmd[n].valid) begin
                    seen_valid[n] = seen_valid[n] + 1;
                end
                // reply countdown before a new accept
                if (pend[n]) begin
                    if (delay[n] == 1) begin
                        link_rsp[n] <= {1'b1, link_mem[n][pend_addr[n]]};
                        pend[n] = 1'b0;
                    end else begin
                        delay[n] = delay[n] - 1;
                    end
                end
                if (link_cmd[n].valid && link_ready[n]) begin
                    if (link_cmd[n].we) begin
                        link_mem[n][link_cmd[n].addr[3:0]] <= link_cmd[n].data;
                        if (log_en && n == WATCH) begin
                            got_q.push_back({link_cmd[n].addr, link_cmd[n].data});
                        end
                    end else if (!stalled[n]) begin
                        pend[n] = 1'b1;
                        pend_addr[n] = link_cmd[n].addr[3:0];
                        delay[n] = 1 + int'($unsigned($random(seed)) % 20);
                    end
                end
            end
        end
    end

    // run limit
    always @(posedge ps_clk) begin
        cyc <= cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Checks failed");
            $display("timeout: run passed %0d cycles without finishing", LIMIT);
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    // one host request, waits for the response pulse
    task automatic do_req(input logic we, input logic [1:0] lane, input logic [3:0] a,
                          input logic [31:0] d, output logic err,
                          output logic [31:0] rdata, output int lat);
        int cnt;
        cnt = 0;
        @(posedge ps_clk);
        host_req.valid <= 1'b1;
        host_req.we    <= we;
        host_req.addr  <= {lane, 21'd0, a};
        host_req.wdata <= d;
        do begin
            @(posedge ps_clk);
            cnt++;
        end while (!host_rsp.valid);
        err   = host_rsp.err;
        rdata = host_rsp.rdata;
        lat   = cnt - 1;
        host_req.valid <= 1'b0;
    endtask

    initial begin
        logic        err;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [1:0]  ln;
        logic [3:0]  a;
        int          lat;
        int          e0;
        int          seen;
        rst_i    <= 1'b1;
        host_req <= '0;
        link_up  <= 4'hf;
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < 16; i++) begin
                ref_mem[n][i] = {16'hc0de, 10'd0, 2'(n), 4'(i)};
            end
        end
        repeat (16) @(posedge ps_clk);
        rst_i <= 1'b0;
        @(posedge ps_clk);

        ////////////////////////////////////////
        // reset values
        ////////////////////////////////////////
        e0 = errors;
        @(posedge ps_clk);
        check_val("host_rsp_o.valid", 32'(host_rsp.valid), 0);
        for (int n = 0; n < 4; n++) begin
            check_val("link_cmd_o.valid", 32'(link_cmd[n].valid), 0);
        end
        check_val("timeout_o", 32'(timeout_o), 0);
        check_val("invalid_o", 32'(invalid_o), 0);
        end_test("reset", e0);

        // write then read back
        e0 = errors;
        for (int i = 0; i < N_WR; i++) begin
            ln = 2'($random(seed));
            a  = 4'($random(seed));
            wd = $random(seed);
            do_req(1'b1, ln, a, wd, err, rd, lat);
            ref_mem[ln][a] = wd;
            check_val("host_rsp_o.err", 32'(err), 0);
            check_val("host_rsp_o.rdata", rd, 0);
            check_val("write latency", 32'(lat), 2);
            do_req(1'b0, ln, a, 0, err, rd, lat);
            check_val("host_rsp_o.err", 32'(err), 0);
            check_val("host_rsp_o.rdata", rd, ref_mem[ln][a]);
        end
        end_test("write_read", e0);

        // lane 2 link down
        e0 = errors;
        @(posedge ps_clk);
        link_up <= 4'b1011;
        seen = seen_valid[2];
        do_req(1'b1, 2'd2, 4'd3, 32'h1234, err, rd, lat);
        check_val("host_rsp_o.err", 32'(err), 1);
        check_val("write latency", 32'(lat), 2);
        do_req(1'b0, 2'd2, 4'd3, 0, err, rd, lat);
        check_val("host_rsp_o.err", 32'(err), 1);
        check_val("host_rsp_o.rdata", rd, `BRIDGE_ERR_DATA);
        check_val("read latency", 32'(lat), 2);
        check_val("invalid_o", 32'(invalid_o), 32'h4);
        // long enough for a stray command to reach the link
        repeat (4) @(posedge ps_clk);
        check_val("lane 2 link_cmd_o.valid cycles", 32'(seen_valid[2]), 32'(seen));
        link_up <= 4'hf;
        end_test("link_down", e0);

        // stalled lane 0
        e0 = errors;
        stalled = 4'b0001;
        do_req(1'b0, 2'd0, 4'd5, 0, err, rd, lat);
        check_val("host_rsp_o.err", 32'(err), 1);
        check_val("host_rsp_o.rdata", rd, `BRIDGE_ERR_DATA);
        check_val("timeout_o", 32'(timeout_o), 32'h1);
        checks++;
        if (lat < `BRIDGE_TIMEOUT) begin
            errors++;
            $display("timed-out read answered after only %0d cycles", lat);
        end
        stalled = 4'b0000;
        end_test("read_timeout", e0);

        ////////////////////////////////////////
        // burst under back-pressure
        ////////////////////////////////////////
        e0 = errors;
        ready_rand = 1'b1;
        log_en = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            a  = 4'($unsigned($random(seed)) % 4);
            wd = $random(seed);
            exp_q.push_back({21'd0, a, wd});
            ref_mem[WATCH][a] = wd;
            do_req(1'b1, 2'(WATCH), a, wd, err, rd, lat);
            check_val("host_rsp_o.err", 32'(err), 0);
        end
        for (int i = 0; i < 4; i++) begin
            do_req(1'b0, 2'(WATCH), 4'(i), 0, err, rd, lat);
            check_val("host_rsp_o.err", 32'(err), 0);
            check_val("host_rsp_o.rdata", rd, ref_mem[WATCH][i]);
        end
        ready_rand = 1'b0;
        log_en = 1'b0;
        check_val("writes seen on link", 32'(got_q.size()), 32'(exp_q.size()));
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_val("link_cmd_o.data", got_q[i][31:0], exp_q[i][31:0]);
            check_val("link_cmd_o.addr", 32'(got_q[i][56:32]), 32'(exp_q[i][56:32]));
        end
        end_test("back_pressure", e0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
